// File: tests/erx_tests.txt
# Receive core vectors, one command per line, numeric fields in hex
# c page valid newpage | m mmu_en rx_enable | w wr rq rr wait (0 low, 1 held, 2 random)
# t write datamode ctrlmode dstaddr srcaddr data | x same as t, checks 3-cycle latency
# s cycles | u rd_wait wr_wait_up | d wait until every port has drained
# Latency through empty queues, translation off
w 0 0 0
m 0 1
x 1 2 0 00100040 00000000 a0000001
x 0 2 3 00200080 80000010 00000000
x 1 2 0 81000004 00000000 a0000002
# Remap and classification with translation off
t 1 0 1 fff12345 00000000 a0000003
t 1 1 2 01a00010 00000000 a0000004
t 0 2 0 7c300020 80000020 00000000
t 1 2 0 81080008 00000000 a0000005
t 0 3 4 12345678 80000030 00000000
t 1 2 f 810fff00 00000000 a0000006
d
# Page table, slot 5 maps onto the read tag page, slot 6 invalid
c 3 1 abc
c 5 1 810
c 6 0 555
m 1 1
t 1 2 0 00300044 00000000 b0000001
t 1 2 0 00500048 00000000 b0000002
t 0 2 0 00600050 80000040 00000000
t 1 2 0 00700054 00000000 b0000003
t 1 2 0 81000058 00000000 b0000004
t 1 2 0 0063005c 00000000 b0000005
d
# Receive disabled, nothing may appear
m 1 0
t 1 2 0 00300060 00000000 c0000001
t 0 2 0 00200064 80000050 00000000
t 1 2 0 81000068 00000000 c0000002
d
# Write port held until upstream wait rises, reads keep flowing
m 0 1
w 1 0 0
t 1 2 0 00000100 00000000 d0000001
t 1 2 0 00000104 00000000 d0000002
t 1 2 0 00000108 00000000 d0000003
t 1 2 0 0000010c 00000000 d0000004
t 1 2 0 00000110 00000000 d0000005
t 1 2 0 00000114 00000000 d0000006
t 1 2 0 00000118 00000000 d0000007
t 1 2 0 0000011c 00000000 d0000008
t 1 2 0 00000120 00000000 d0000009
t 1 2 0 00000124 00000000 d000000a
t 1 2 0 00000128 00000000 d000000b
t 1 2 0 0000012c 00000000 d000000c
t 1 2 0 00000130 00000000 d000000d
s 4
u 0 1
t 0 2 0 00200200 80000060 00000000
t 0 2 0 00200204 80000064 00000000
w 0 0 0
d
# Random drain waits on all ports
w 2 2 2
t 1 2 0 00400300 00000000 e0000001
t 0 2 0 00400304 80000070 00000000
t 1 2 0 81000308 00000000 e0000002
t 1 1 3 0040030c 00000000 e0000003
t 0 0 0 00400310 80000074 00000000
t 1 2 0 81000314 00000000 e0000004
d
w 0 0 0

// File: tb.f
+incdir+common
common/emesh_pkg.sv
common/erx_cfg_pkg.sv
source/erx_mmu.sv
source/erx_disty.sv
source/erx_fifo.sv
source/erx_core.sv
tests/tb_clock.sv
tests/tb_erx_core.sv

// File: Makefile
# Verilator flow for the eMesh receive core
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_erx_core
RTL_TOP   ?= erx_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing
FAIL_MSG  ?= Checks failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_erx_core.sv
// Testbench for the receive core, commands come from tests/erx_tests.txt
// Inputs change on the falling edge, outputs are sampled on the rising edge
// Source side honors rd_wait and wr_wait_up before presenting a transaction
// Wait mode 2 draws drain waits from $random with a fixed seed

`timescale 1ns/100ps
`include "erx_defines.svh"

module tb_erx_core;

  localparam string       VEC_FILE   = "tests/erx_tests.txt";
  localparam int          REMAP_BITS = `ERX_REMAP_BITS;
  localparam logic [31:0] REMAP_ADDR = `ERX_REMAP_ADDR;

  logic                     clk;
  logic                     rst_n;
  logic                     mmu_en;
  logic                     rx_enable;
  logic                     cfg_write;
  logic [3:0]               cfg_page;
  erx_cfg_pkg::page_entry_t cfg_entry;
  logic                     in_access;
  logic                     in_write;
  logic [1:0]               in_datamode;
  logic [3:0]               in_ctrlmode;
  logic [31:0]              in_dstaddr;
  logic [31:0]              in_srcaddr;
  logic [31:0]              in_data;
  // Drain waits, 0 low, 1 held, 2 random
  logic                     wr_wait = 1'b0;
  logic                     rq_wait = 1'b0;
  logic                     rr_wait = 1'b0;
  logic [1:0]               wr_mode = 2'd0;
  logic [1:0]               rq_mode = 2'd0;
  logic [1:0]               rr_mode = 2'd0;
  logic                     rd_wait;
  logic                     wr_wait_up;
  logic                     wr_access;
  logic [1:0]               wr_datamode;
  logic [3:0]               wr_ctrlmode;
  logic [31:0]              wr_dstaddr;
  logic [31:0]              wr_data;
  logic                     rq_access;
  logic                     rq_write;
  logic [1:0]               rq_datamode;
  logic [3:0]               rq_ctrlmode;
  logic [31:0]              rq_dstaddr;
  logic [31:0]              rq_srcaddr;
  logic [31:0]              rq_data;
  logic                     rr_access;
  logic [1:0]               rr_datamode;
  logic [3:0]               rr_ctrlmode;
  logic [31:0]              rr_dstaddr;
  logic [31:0]              rr_data;

  // Page table model and per-port expected queues
  logic [`ERX_PAGE_ENTRIES-1:0] pt_valid = '0;
  logic [11:0]                  pt_page [`ERX_PAGE_ENTRIES];
  emesh_pkg::emesh_pkt_t        exp_wr [$];
  emesh_pkg::emesh_pkt_t        exp_rq [$];
  emesh_pkg::emesh_pkt_t        exp_rr [$];
  string                        vec [$];
  int                           seed = 97;
  int                           checks = 0;
  int                           errors = 0;
  int                           mon_checks = 0;
  int                           mon_errors = 0;
  int                           cycle_limit = 0;

  tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(3)) u_clock (.clk, .rst_n);

  erx_core uut (.*);

  // ############################################################
  // Reference model
  // ############################################################

  // Translate, classify on the translated page, remap on a miss
  task automatic expect_txn(input emesh_pkg::emesh_pkt_t pkt,
                            output erx_cfg_pkg::dest_class_e cls);
    logic [3:0]  idx;
    logic        hit;
    logic [31:0] addr;
    logic [31:0] remap_mask;
    begin
      idx  = pkt.dstaddr[23:20];
      hit  = mmu_en && pt_valid[idx];
      addr = pkt.dstaddr;
      // Valid page replaces the top 12 bits
      if (hit)
        addr[31:20] = pt_page[idx];
      if (!rx_enable)
        cls = erx_cfg_pkg::CLASS_NONE;
      else if (!pkt.write)
        cls = erx_cfg_pkg::CLASS_RQ;
      else if (addr[31:20] == `ERX_READ_TAG_PAGE)
        cls = erx_cfg_pkg::CLASS_RR;
      else
        cls = erx_cfg_pkg::CLASS_WR;
      // Ones over the bits taken from the remap value
      remap_mask = ~(32'hffff_ffff >> REMAP_BITS);
      if (!hit)
        addr = (addr & ~remap_mask) | (REMAP_ADDR & remap_mask);
      pkt.dstaddr = addr;
      case (cls)
        erx_cfg_pkg::CLASS_WR: exp_wr.push_back(pkt);
        erx_cfg_pkg::CLASS_RQ: exp_rq.push_back(pkt);
        erx_cfg_pkg::CLASS_RR: exp_rr.push_back(pkt);
        default: ;
      endcase
    end
  endtask

  function automatic logic port_access(input erx_cfg_pkg::dest_class_e cls);
    case (cls)
      erx_cfg_pkg::CLASS_WR: return wr_access;
      erx_cfg_pkg::CLASS_RQ: return rq_access;
      erx_cfg_pkg::CLASS_RR: return rr_access;
      default: return 1'b0;
    endcase
  endfunction

  // ############################################################
  // Output side, drain waits and transfer checks
  // ############################################################

  always @(negedge clk)
  begin
    wr_wait = (wr_mode == 2'd2) ? (($random(seed) & 1) != 0) : wr_mode[0];
    rq_wait = (rq_mode == 2'd2) ? (($random(seed) & 1) != 0) : rq_mode[0];
    rr_wait = (rr_mode == 2'd2) ? (($random(seed) & 1) != 0) : rr_mode[0];
  end

  task automatic check_output(input string port, input erx_cfg_pkg::dest_class_e cls,
                              input emesh_pkg::emesh_pkt_t got);
    emesh_pkg::emesh_pkt_t exp;
    int                    pending;
    begin
      pending = (cls == erx_cfg_pkg::CLASS_WR) ? exp_wr.size() :
                (cls == erx_cfg_pkg::CLASS_RQ) ? exp_rq.size() : exp_rr.size();
      mon_checks++;
      assert (pending != 0)
      else
      begin
        mon_errors++;
        $display("Unexpected transfer on the %s port at %0t", port, $time);
      end
      if (pending != 0)
      begin
        case (cls)
          erx_cfg_pkg::CLASS_WR: exp = exp_wr.pop_front();
          erx_cfg_pkg::CLASS_RQ: exp = exp_rq.pop_front();
          default: exp = exp_rr.pop_front();
        endcase
        // Short payload ports carry no write flag or srcaddr
        if (cls != erx_cfg_pkg::CLASS_RQ)
        begin
          got.write   = exp.write;
          got.srcaddr = exp.srcaddr;
        end
        mon_checks++;
        assert (got == exp)
        else
        begin
          mon_errors++;
          $display("error %0t: %s port got %h expected %h", $time, port, got, exp);
        end
      end
    end
  endtask

  // Transfer is access high with wait low at the rising edge
  always @(posedge clk)
  begin
    if (rst_n && wr_access && !wr_wait)
      check_output("wr", erx_cfg_pkg::CLASS_WR,
                   {1'b1, wr_datamode, wr_ctrlmode, wr_dstaddr, 32'h0, wr_data});
    if (rst_n && rq_access && !rq_wait)
      check_output("rq", erx_cfg_pkg::CLASS_RQ,
                   {rq_write, rq_datamode, rq_ctrlmode, rq_dstaddr, rq_srcaddr, rq_data});
    if (rst_n && rr_access && !rr_wait)
      check_output("rr", erx_cfg_pkg::CLASS_RR,
                   {1'b1, rr_datamode, rr_ctrlmode, rr_dstaddr, 32'h0, rr_data});
  end

  // ############################################################
  // Input side
  // ############################################################

  // Hold back while the matching upstream wait is high
  task automatic drive_txn(input emesh_pkg::emesh_pkt_t pkt,
                           output erx_cfg_pkg::dest_class_e cls);
    while (pkt.write ? wr_wait_up : rd_wait)
    begin
      in_access = 1'b0;
      @(negedge clk);
    end
    in_write    = pkt.write;
    in_datamode = pkt.datamode;
    in_ctrlmode = pkt.ctrlmode;
    in_dstaddr  = pkt.dstaddr;
    in_srcaddr  = pkt.srcaddr;
    in_data     = pkt.data;
    in_access   = 1'b1;
    expect_txn(pkt, cls);
    @(negedge clk);
  endtask

  task automatic drain_queues();
    in_access = 1'b0;
    while (exp_wr.size() + exp_rq.size() + exp_rr.size() != 0)
      @(negedge clk);
    // Room for stray transfers of dropped items
    repeat (4) @(negedge clk);
  endtask

  task automatic run_command(input string line);
    logic [7:0]               op;
    logic [31:0]              fld [6];
    emesh_pkg::emesh_pkt_t    pkt;
    erx_cfg_pkg::dest_class_e cls;
    int                       k;
    begin
      op  = line[0];
      fld = '{default: '0};
      void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5]));
      pkt = '{write: fld[0][0], datamode: fld[1][1:0], ctrlmode: fld[2][3:0],
              dstaddr: fld[3], srcaddr: fld[4], data: fld[5]};
      // Source idles except while streaming
      if (op != "t")
        in_access = 1'b0;
      case (op)
        "t": drive_txn(pkt, cls);
        "x":
        begin
          drain_queues();
          drive_txn(pkt, cls);
          in_access = 1'b0;
          // Access must rise on the third edge, not earlier
          for (k = 1; k <= 3; k++)
          begin
            checks++;
            assert (port_access(cls) == (k == 3))
            else
            begin
              errors++;
              $display("error %0t: access %b at cycle %0d after input", $time,
                       port_access(cls), k);
            end
            if (k < 3)
              @(negedge clk);
          end
        end
        "c":
        begin
          cfg_page        = fld[0][3:0];
          cfg_entry.valid = fld[1][0];
          cfg_entry.page  = fld[2][11:0];
          cfg_write       = 1'b1;
          pt_valid[fld[0][3:0]] = fld[1][0];
          pt_page[fld[0][3:0]]  = fld[2][11:0];
          @(negedge clk);
          cfg_write = 1'b0;
        end
        "m":
        begin
          // Let in-flight items clear both stages first
          repeat (3) @(negedge clk);
          mmu_en    = fld[0][0];
          rx_enable = fld[1][0];
        end
        "w":
        begin
          // Let in-flight items reach their ports first
          repeat (3) @(negedge clk);
          // A port with its wait low keeps flowing whatever the others do
          checks++;
          assert ((wr_mode != 2'd0 || exp_wr.size() == 0) &&
                  (rq_mode != 2'd0 || exp_rq.size() == 0) &&
                  (rr_mode != 2'd0 || exp_rr.size() == 0))
          else
          begin
            errors++;
            $display("error %0t: free ports still pending wr %0d rq %0d rr %0d", $time,
                     exp_wr.size(), exp_rq.size(), exp_rr.size());
          end
          wr_mode = fld[0][1:0];
          rq_mode = fld[1][1:0];
          rr_mode = fld[2][1:0];
        end
        "s": repeat (fld[0]) @(negedge clk);
        "u":
        begin
          checks++;
          assert (rd_wait == fld[0][0] && wr_wait_up == fld[1][0])
          else
          begin
            errors++;
            $display("error %0t: upstream wait rd %b wr %b, expected %b %b", $time,
                     rd_wait, wr_wait_up, fld[0][0], fld[1][0]);
          end
        end
        "d": drain_queues();
        default:
        begin
          errors++;
          $display("Unknown command in the vector file: %s", line);
        end
      endcase
    end
  endtask

  // ############################################################
  // Main sequence and watchdog
  // ############################################################

  initial
  begin : main
    int    fd;
    string line;
    mmu_en      = 1'b0;
    rx_enable   = 1'b0;
    cfg_write   = 1'b0;
    cfg_page    = '0;
    cfg_entry   = '0;
    in_access   = 1'b0;
    in_write    = 1'b0;
    in_datamode = '0;
    in_ctrlmode = '0;
    in_dstaddr  = '0;
    in_srcaddr  = '0;
    in_data     = '0;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open the vector file %s", VEC_FILE);
    end
    else
    begin
      // Keep command lines only
      while (!$feof(fd))
      begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#")
          vec.push_back(line);
      end
      $fclose(fd);
    end
    cycle_limit = vec.size() * 40 + 200;
    wait (rst_n === 1'b1);
    @(negedge clk);
    checks++;
    assert (!wr_access && !rq_access && !rr_access)
    else
    begin
      errors++;
      $display("error %0t: an access output is high after reset", $time);
    end
    foreach (vec[i])
      run_command(vec[i]);
    in_access = 1'b0;
    // Nothing may remain undelivered
    checks++;
    assert (exp_wr.size() + exp_rq.size() + exp_rr.size() == 0)
    else
    begin
      errors++;
      $display("Transactions never arrived: wr %0d, rq %0d, rr %0d",
               exp_wr.size(), exp_rq.size(), exp_rr.size());
    end
    $display("Summary: %0d checks, %0d errors", checks + mon_checks, errors + mon_errors);
    if (errors + mon_errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial
  begin : watchdog
    wait (cycle_limit > 0);
    repeat (cycle_limit) @(posedge clk);
    $display("Timeout: the run was still busy after %0d cycles", cycle_limit);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: tests/tb_clock.sv
// Clock and reset source for the testbench
// Reset released on a falling edge after RESET_CYCLES rising edges

`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  // Free-running clock, starts low
  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD_NS / 2) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    // Release away from the active edge
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: source/erx_core.sv
// Receive transaction core: translate, distribute, then queue
// Upstream wait is combinational from the FIFO prog-full flags
// Source must honor rd_wait for reads and wr_wait_up for writes,
// one cycle of late reaction is covered by the threshold

`timescale 1ns/100ps
`include "erx_defines.svh"

module erx_core (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                mmu_en,
  input  logic                                rx_enable,
  input  logic                                cfg_write,
  input  logic [$clog2(`ERX_PAGE_ENTRIES)-1:0] cfg_page,
  input  erx_cfg_pkg::page_entry_t            cfg_entry,
  input  logic                                in_access,
  input  logic                                in_write,
  input  logic [1:0]                          in_datamode,
  input  logic [3:0]                          in_ctrlmode,
  input  logic [31:0]                         in_dstaddr,
  input  logic [31:0]                         in_srcaddr,
  input  logic [31:0]                         in_data,
  input  logic                                wr_wait,
  input  logic                                rq_wait,
  input  logic                                rr_wait,
  output logic                                rd_wait,
  output logic                                wr_wait_up,
  output logic                                wr_access,
  output logic [1:0]                          wr_datamode,
  output logic [3:0]                          wr_ctrlmode,
  output logic [31:0]                         wr_dstaddr,
  output logic [31:0]                         wr_data,
  output logic                                rq_access,
  output logic                                rq_write,
  output logic [1:0]                          rq_datamode,
  output logic [3:0]                          rq_ctrlmode,
  output logic [31:0]                         rq_dstaddr,
  output logic [31:0]                         rq_srcaddr,
  output logic [31:0]                         rq_data,
  output logic                                rr_access,
  output logic [1:0]                          rr_datamode,
  output logic [3:0]                          rr_ctrlmode,
  output logic [31:0]                         rr_dstaddr,
  output logic [31:0]                         rr_data
);

  // Translation stage to distributor
  logic        st_access;
  logic        st_write;
  logic [1:0]  st_datamode;
  logic [3:0]  st_ctrlmode;
  logic [31:0] st_dstaddr;
  logic [31:0] st_srcaddr;
  logic [31:0] st_data;
  logic        st_translated;

  // Distributor to queues
  logic                  wr_push;
  logic                  rq_push;
  logic                  rr_push;
  emesh_pkg::emesh_pkt_t dist_pkt;
  emesh_pkg::emesh_wr_t  dist_wr;

  // Queue heads and fill flags
  emesh_pkg::emesh_wr_t  wr_head;
  emesh_pkg::emesh_pkt_t rq_head;
  emesh_pkg::emesh_wr_t  rr_head;
  logic                  wr_full;
  logic                  rq_full;
  logic                  rr_full;

  erx_mmu u_mmu (
    .clk, .rst_n, .mmu_en, .cfg_write, .cfg_page, .cfg_entry,
    .in_access, .in_write, .in_datamode, .in_ctrlmode,
    .in_dstaddr, .in_srcaddr, .in_data,
    .st_access, .st_write, .st_datamode, .st_ctrlmode,
    .st_dstaddr, .st_srcaddr, .st_data, .st_translated
  );

  erx_disty u_disty (
    .clk, .rst_n, .rx_enable,
    .st_access, .st_write, .st_datamode, .st_ctrlmode,
    .st_dstaddr, .st_srcaddr, .st_data, .st_translated,
    .wr_push, .rq_push, .rr_push, .out_pkt(dist_pkt)
  );

  // Write and response queues take the short payload
  assign dist_wr = '{datamode: dist_pkt.datamode, ctrlmode: dist_pkt.ctrlmode,
                     dstaddr: dist_pkt.dstaddr, data: dist_pkt.data};

  // ############################################################
  // Queues
  // ############################################################

  erx_fifo #(.payload_t(emesh_pkg::emesh_wr_t)) fifo_wr (
    .clk, .rst_n, .push(wr_push), .push_data(dist_wr), .wait_in(wr_wait),
    .access(wr_access), .pop_data(wr_head), .prog_full(wr_full)
  );

  erx_fifo #(.payload_t(emesh_pkg::emesh_pkt_t)) fifo_rq (
    .clk, .rst_n, .push(rq_push), .push_data(dist_pkt), .wait_in(rq_wait),
    .access(rq_access), .pop_data(rq_head), .prog_full(rq_full)
  );

  erx_fifo #(.payload_t(emesh_pkg::emesh_wr_t)) fifo_rr (
    .clk, .rst_n, .push(rr_push), .push_data(dist_wr), .wait_in(rr_wait),
    .access(rr_access), .pop_data(rr_head), .prog_full(rr_full)
  );

  assign {wr_datamode, wr_ctrlmode, wr_dstaddr, wr_data} = wr_head;
  assign {rq_write, rq_datamode, rq_ctrlmode, rq_dstaddr, rq_srcaddr, rq_data} = rq_head;
  assign {rr_datamode, rr_ctrlmode, rr_dstaddr, rr_data} = rr_head;

  // Same grouping as the eMesh endpoint: reads vs. write-type traffic
  assign rd_wait    = rq_full;
  assign wr_wait_up = wr_full | rr_full;

endmodule

// File: source/erx_fifo.sv
// Synchronous FIFO with eMesh access/wait read side
// Access is high whenever the FIFO holds data; head is shown directly
// A write lands on the edge after push, so an empty FIFO raises
// access in the next cycle
// Overflow is prevented upstream by the prog-full threshold

`timescale 1ns/100ps
`include "erx_defines.svh"

module erx_fifo #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     wait_in,
  output logic     access,
  output payload_t pop_data,
  output logic     prog_full
);

  localparam int DEPTH = `ERX_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  // Wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // ############################################################
  // Read side
  // ############################################################

  assign access    = (count != '0);
  // Transfer when access high and wait low
  assign pop       = access & ~wait_in;
  assign pop_data  = mem[rd_ptr];
  assign prog_full = (count >= CNT_W'(`ERX_FIFO_FULL_LEVEL));

  // ############################################################
  // Storage and pointers
  // ############################################################

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      // Count moves only when one side is active
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // Threshold must leave room for everything still in the pipeline
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count != CNT_W'(DEPTH)));

  // eMesh rule: a stalled head stays put until taken
  a_hold_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (access && wait_in) |=> (access && $stable(pop_data)));

endmodule

// File: source/erx_disty.sv
// Distributor stage, one cycle
// Classifies on the dest address before remap; remap only touches the
// top ERX_REMAP_BITS, which lie inside the 12-bit tag compare
// Everything is dropped while rx_enable is low

`timescale 1ns/100ps
`include "erx_defines.svh"

module erx_disty (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx_enable,
  input  logic                    st_access,
  input  logic                    st_write,
  input  logic [1:0]              st_datamode,
  input  logic [3:0]              st_ctrlmode,
  input  logic [31:0]             st_dstaddr,
  input  logic [31:0]             st_srcaddr,
  input  logic [31:0]             st_data,
  input  logic                    st_translated,
  output logic                    wr_push,
  output logic                    rq_push,
  output logic                    rr_push,
  output emesh_pkg::emesh_pkt_t   out_pkt
);

  localparam int          REMAP_BITS = `ERX_REMAP_BITS;
  localparam logic [31:0] REMAP_ADDR = `ERX_REMAP_ADDR;
  localparam logic [11:0] READ_TAG   = `ERX_READ_TAG_PAGE;

  erx_cfg_pkg::dest_class_e dest_class;
  logic [31:0]              final_addr;

  // ############################################################
  // Remap when no translation happened
  // ############################################################

  assign final_addr = st_translated ? st_dstaddr :
                      {REMAP_ADDR[31 -: REMAP_BITS], st_dstaddr[31-REMAP_BITS:0]};

  // ############################################################
  // Classification
  // ############################################################

  always_comb
  begin
    if (!st_access || !rx_enable)
      dest_class = erx_cfg_pkg::CLASS_NONE;
    else if (!st_write)
      dest_class = erx_cfg_pkg::CLASS_RQ;
    // Write to the tag page is a returning read
    else if (st_dstaddr[31:20] == READ_TAG)
      dest_class = erx_cfg_pkg::CLASS_RR;
    else
      dest_class = erx_cfg_pkg::CLASS_WR;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_push <= 1'b0;
      rq_push <= 1'b0;
      rr_push <= 1'b0;
    end
    else
    begin
      wr_push <= (dest_class == erx_cfg_pkg::CLASS_WR);
      rq_push <= (dest_class == erx_cfg_pkg::CLASS_RQ);
      rr_push <= (dest_class == erx_cfg_pkg::CLASS_RR);
    end
  end

  // Shared payload for all three queues
  always_ff @(posedge clk)
  begin
    out_pkt.write    <= st_write;
    out_pkt.datamode <= st_datamode;
    out_pkt.ctrlmode <= st_ctrlmode;
    out_pkt.dstaddr  <= final_addr;
    out_pkt.srcaddr  <= st_srcaddr;
    out_pkt.data     <= st_data;
  end

  // One shared payload, so only one queue may take it
  a_one_push: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({wr_push, rq_push, rr_push}));

endmodule

// File: source/erx_mmu.sv
// Address translation stage, one cycle
// Page table is indexed by dstaddr[23:20] and replaces dstaddr[31:20]
// A config write and a lookup of the same slot in one cycle see the
// old entry

`timescale 1ns/100ps
`include "erx_defines.svh"

module erx_mmu (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                mmu_en,
  input  logic                                cfg_write,
  input  logic [$clog2(`ERX_PAGE_ENTRIES)-1:0] cfg_page,
  input  erx_cfg_pkg::page_entry_t            cfg_entry,
  input  logic                                in_access,
  input  logic                                in_write,
  input  logic [1:0]                          in_datamode,
  input  logic [3:0]                          in_ctrlmode,
  input  logic [31:0]                         in_dstaddr,
  input  logic [31:0]                         in_srcaddr,
  input  logic [31:0]                         in_data,
  output logic                                st_access,
  output logic                                st_write,
  output logic [1:0]                          st_datamode,
  output logic [3:0]                          st_ctrlmode,
  output logic [31:0]                         st_dstaddr,
  output logic [31:0]                         st_srcaddr,
  output logic [31:0]                         st_data,
  output logic                                st_translated
);

  localparam int IDX_W = $clog2(`ERX_PAGE_ENTRIES);

  // Valid bits are control state, pages are payload
  logic [`ERX_PAGE_ENTRIES-1:0] page_valid;
  logic [11:0]                  page_addr [`ERX_PAGE_ENTRIES];
  logic [IDX_W-1:0]             lookup_idx;
  logic                         hit;

  // ############################################################
  // Page table
  // ############################################################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      page_valid <= '0;
    else if (cfg_write)
      page_valid[cfg_page] <= cfg_entry.valid;
  end

  always_ff @(posedge clk)
  begin
    if (cfg_write)
      page_addr[cfg_page] <= cfg_entry.page;
  end

  // ############################################################
  // Lookup and stage register
  // ############################################################

  assign lookup_idx = in_dstaddr[20 +: IDX_W];
  // Hit only with translation on and a valid slot
  assign hit        = mmu_en & page_valid[lookup_idx];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      st_access <= 1'b0;
    else
      st_access <= in_access;
  end

  always_ff @(posedge clk)
  begin
    st_write      <= in_write;
    st_datamode   <= in_datamode;
    st_ctrlmode   <= in_ctrlmode;
    st_dstaddr    <= hit ? {page_addr[lookup_idx], in_dstaddr[19:0]} : in_dstaddr;
    st_srcaddr    <= in_srcaddr;
    st_data       <= in_data;
    // Tells the distributor to skip the fixed remap
    st_translated <= hit;
  end

  // Write flag decides the queue, so it must be known
  a_write_known: assert property (@(posedge clk) disable iff (!rst_n)
    in_access |-> !$isunknown(in_write));

endmodule

// File: common/erx_cfg_pkg.sv
// Configuration and classification types for the receive core
// Page entry holds only the upper 12 address bits of the target

package erx_cfg_pkg;

  // One page table slot
  typedef struct packed {
    logic        valid;
    // Replaces dstaddr[31:20] on a hit
    logic [11:0] page;
  } page_entry_t;

  // Destination queue of a transaction
  typedef enum logic [1:0] {
    CLASS_NONE = 2'd0,
    // Plain write
    CLASS_WR   = 2'd1,
    // Read request
    CLASS_RQ   = 2'd2,
    // Write to the read tag page
    CLASS_RR   = 2'd3
  } dest_class_e;

endpackage

// File: common/emesh_pkg.sv
// eMesh transaction payload types
// Field order follows the eMesh bus: write, datamode, ctrlmode,
// dstaddr, srcaddr, data
// Write and response queues drop srcaddr and the write flag

package emesh_pkg;

  // Full transaction, as carried by the read request queue
  typedef struct packed {
    logic        write;
    // 0 byte, 1 half, 2 word, 3 double
    logic [1:0]  datamode;
    logic [3:0]  ctrlmode;
    logic [31:0] dstaddr;
    // Return address for reads
    logic [31:0] srcaddr;
    logic [31:0] data;
  } emesh_pkt_t;

  // Write or read response
  // Write flag implied by the queue, srcaddr not needed
  typedef struct packed {
    logic [1:0]  datamode;
    logic [3:0]  ctrlmode;
    logic [31:0] dstaddr;
    logic [31:0] data;
  } emesh_wr_t;

endpackage

// File: common/erx_defines.svh
// Build-time constants for the eMesh receive core
// ERX_FIFO_FULL_LEVEL must leave room for the two pipeline stages
// plus one cycle of upstream wait reaction, so keep depth - 3 or lower
// ERX_PAGE_ENTRIES must be a power of two, indexed from dstaddr[20 +: n]

`ifndef ERX_DEFINES_SVH
`define ERX_DEFINES_SVH

// ############################################################
// Address classification and remap
// ############################################################

// Upper 12 dest bits that mark a write as a read response
`define ERX_READ_TAG_PAGE 12'h810

// Upper dest bits replaced when translation is off
`define ERX_REMAP_BITS 7
// Source of the replaced bits, only the top ERX_REMAP_BITS matter
`define ERX_REMAP_ADDR 32'h3E000000

// ############################################################
// Queues and page table
// ############################################################

`define ERX_FIFO_DEPTH 16
// Prog-full at or above this fill level
`define ERX_FIFO_FULL_LEVEL (`ERX_FIFO_DEPTH - 3)

`define ERX_PAGE_ENTRIES 16

`endif
